//--- Makefile
TOP := store_issue_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f store_issue.f \
	  --top-module $(TOP) -Mdir obj_dir
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	  echo "$$out" | grep -q "^Simulation PASSED$$"

clean:
	rm -rf obj_dir

//--- bench/store_issue_model.svh
`ifndef STORE_ISSUE_MODEL_SVH
`define STORE_ISSUE_MODEL_SVH

// offset of byte b of a store, wrapped inside the 128-byte line
function automatic int byte_off(input line_off_t addr, input int b);
  return (int'(addr) + b) % 128;
endfunction

function automatic int byte_count(input size_e size);
  return 1 << int'(size);
endfunction

function automatic bank_idx_t expected_bgn_bank(input line_off_t addr);
  return bank_idx_t'(byte_off(addr, 0) / 4);
endfunction

function automatic bank_idx_t expected_end_bank(input line_off_t addr, input size_e size);
  return bank_idx_t'(byte_off(addr, byte_count(size) - 1) / 4);
endfunction

// enables of the bytes that fall into one given bank
function automatic ben_t expected_ben(input line_off_t addr, input size_e size,
                                      input bank_idx_t bank);
  ben_t ben;
  int   off;
  ben = '0;
  for (int b = 0; b < byte_count(size); b++) begin
    off = byte_off(addr, b);
    if (bank_idx_t'(off / 4) == bank) ben[off % 4] = 1'b1;
  end
  return ben;
endfunction

function automatic bank_mask_t expected_mask(input line_off_t addr, input size_e size);
  bank_mask_t mask;
  mask = '0;
  for (int b = 0; b < byte_count(size); b++) begin
    mask[byte_off(addr, b) / 4] = 1'b1;
  end
  return mask;
endfunction

// every raw byte moves up by the byte-in-bank offset
function automatic wide_data_t expected_data(input line_off_t addr, input store_data_t data);
  wide_data_t out;
  out = '0;
  for (int b = 0; b < 16; b++) begin
    out[(b + int'(addr[1:0])) * 8 +: 8] = data[b * 8 +: 8];
  end
  return out;
endfunction

`endif

//--- bench/store_issue_tb.sv
`timescale 1ns/1ps

module store_issue_tb;

  import store_issue_pkg::*;

  `include "store_issue_model.svh"

  logic        clk;
  logic        rst_n;
  logic        st_stall;
  logic        req0_valid, req1_valid;
  logic        req0_ready, req1_ready;
  line_off_t   req0_addr, req1_addr;
  size_e       req0_size, req1_size;
  store_data_t req0_data, req1_data;
  logic        st0_en, st1_en;
  line_off_t   st0_addr, st1_addr;
  size_e       st0_size, st1_size;
  bank_idx_t   st0_bgn_bank, st0_end_bank, st1_bgn_bank, st1_end_bank;
  ben_t        st0_bgn_ben, st0_end_ben, st1_bgn_ben, st1_end_ben;
  wide_data_t  st0_data, st1_data;

  // addr, size and raw data of one accepted store
  logic [137:0] q0[$];
  logic [137:0] q1[$];
  logic [31:0]  rng_state;
  int           err_count;
  int           fail_count;
  logic         stall_d1, stall_d2;
  logic         took0, took1;
  int           wait0, wait1;
  logic [31:0]  r;

  store_issue_top DUT (.*);

  always #4 clk = ~clk;

  function logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function store_data_t random_data();
    return {next_rand(), next_rand(), next_rand(), next_rand()};
  endfunction

  task automatic check_issue(input int lane, input logic [137:0] exp, input line_off_t addr,
                             input size_e size, input bank_idx_t bgn_bank,
                             input bank_idx_t end_bank, input ben_t bgn_ben,
                             input ben_t end_ben, input wide_data_t data);
    line_off_t   e_addr;
    size_e       e_size;
    store_data_t e_data;
    bank_idx_t   e_bgn;
    bank_idx_t   e_end;
    e_addr = exp[137:131];
    e_size = size_e'(exp[130:128]);
    e_data = exp[127:0];
    e_bgn  = expected_bgn_bank(e_addr);
    e_end  = expected_end_bank(e_addr, e_size);
    assert (addr == e_addr && size == e_size) else begin
      err_count++;
      $display("ERROR %0t: lane %0d issued addr %0h size %0d, expected addr %0h size %0d",
               $time, lane, addr, size, e_addr, e_size);
    end
    assert (bgn_bank == e_bgn && end_bank == e_end) else begin
      err_count++;
      $display("ERROR %0t: lane %0d banks %0d..%0d, expected %0d..%0d",
               $time, lane, bgn_bank, end_bank, e_bgn, e_end);
    end
    assert (bgn_ben == expected_ben(e_addr, e_size, e_bgn) &&
            end_ben == expected_ben(e_addr, e_size, e_end)) else begin
      err_count++;
      $display("ERROR %0t: lane %0d byte enables %h/%h wrong for addr %0h size %0d",
               $time, lane, bgn_ben, end_ben, e_addr, e_size);
    end
    assert (data == expected_data(e_addr, e_data)) else begin
      err_count++;
      $display("ERROR %0t: lane %0d aligned data %h wrong", $time, lane, data);
    end
  endtask

  // scoreboard samples mid-cycle where everything is stable
  always @(negedge clk) begin
    if (!rst_n) begin
      assert (!st0_en && !st1_en && !req0_ready && !req1_ready) else begin
        err_count++;
        $display("ERROR %0t: ready or en output high during reset", $time);
      end
      stall_d1 = 1'b0;
      stall_d2 = 1'b0;
    end else begin
      if (stall_d2) begin
        assert (!st0_en && !st1_en) else begin
          err_count++;
          $display("ERROR %0t: store issued right after a stall", $time);
        end
      end
      assert (!st1_en || st0_en) else begin
        err_count++;
        $display("ERROR %0t: st1_en high without st0_en", $time);
      end
      if (st0_en && st1_en) begin
        assert ((expected_mask(st0_addr, st0_size) & expected_mask(st1_addr, st1_size)) == '0)
        else begin
          err_count++;
          $display("ERROR %0t: issued pair shares a bank", $time);
        end
      end
      if (st0_en) begin
        assert (q0.size() > 0) else begin
          err_count++;
          $display("ERROR %0t: lane 0 issued with no store accepted", $time);
        end
        if (q0.size() > 0) check_issue(0, q0.pop_front(), st0_addr, st0_size, st0_bgn_bank,
                                       st0_end_bank, st0_bgn_ben, st0_end_ben, st0_data);
      end
      if (st1_en) begin
        assert (q1.size() > 0) else begin
          err_count++;
          $display("ERROR %0t: lane 1 issued with no store accepted", $time);
        end
        if (q1.size() > 0) check_issue(1, q1.pop_front(), st1_addr, st1_size, st1_bgn_bank,
                                       st1_end_bank, st1_bgn_ben, st1_end_ben, st1_data);
      end
      if (req0_valid && req0_ready) q0.push_back({req0_addr, req0_size, req0_data});
      if (req1_valid && req1_ready) q1.push_back({req1_addr, req1_size, req1_data});
      stall_d2 = stall_d1;
      stall_d1 = st_stall;
    end
  end

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    st_stall   = 1'b0;
    req0_valid = 1'b0;
    req1_valid = 1'b0;
    req0_addr  = '0;
    req1_addr  = '0;
    req0_size  = size_1;
    req1_size  = size_1;
    req0_data  = '0;
    req1_data  = '0;
    rng_state  = 32'ha11e;
    err_count  = 0;
    fail_count = 0;
    wait0      = 0;
    wait1      = 0;
    repeat (4) @(posedge clk);
    #1 rst_n = 1'b1;
    for (int cyc = 0; cyc < 2000 && fail_count == 0; cyc++) begin
      @(negedge clk);
      took0 = req0_valid && req0_ready;
      took1 = req1_valid && req1_ready;
      @(posedge clk);
      #1;
      if (!req0_valid || took0) begin
        wait0      = 0;
        r          = next_rand();
        req0_valid = (r[1:0] != 2'd0);
        req0_addr  = r[14:8];
        req0_size  = size_e'(r[31:16] % 5);
        req0_data  = random_data();
      end else begin
        wait0++;
        if (wait0 > 64) begin
          fail_count++;
          $display("lane 0 did not accept a store within 64 cycles");
        end
      end
      if (!req1_valid || took1) begin
        wait1      = 0;
        r          = next_rand();
        req1_valid = (r[1:0] != 2'd0);
        req1_addr  = r[14:8];
        req1_size  = size_e'(r[31:16] % 5);
        req1_data  = random_data();
      end else begin
        wait1++;
        if (wait1 > 64) begin
          fail_count++;
          $display("lane 1 did not accept a store within 64 cycles");
        end
      end
      // stall about one cycle in five
      st_stall = (next_rand() % 5 == 0);
    end
    @(negedge clk);
    @(posedge clk);
    #1;
    req0_valid = 1'b0;
    req1_valid = 1'b0;
    st_stall   = 1'b0;
    for (int n = 0; n < 100 && (q0.size() > 0 || q1.size() > 0); n++) begin
      @(posedge clk);
    end
    if (q0.size() > 0 || q1.size() > 0) begin
      fail_count++;
      $display("stores left unissued at the end: lane 0 %0d, lane 1 %0d",
               q0.size(), q1.size());
    end
    $display("errors: %0d, other failures: %0d", err_count, fail_count);
    if (err_count == 0 && fail_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- hdl/store_issue_pkg.sv
package store_issue_pkg;

  // a 128-byte line split into 32-bit banks
  parameter int bank_count = 32;

  // bits 6..2 select the bank, bits 1..0 the byte in it
  typedef logic [6:0] line_off_t;

  typedef logic [4:0] bank_idx_t;

  typedef logic [bank_count-1:0] bank_mask_t;

  // byte enables inside one bank
  typedef logic [3:0] ben_t;

  // up to 16 bytes of raw store data
  typedef logic [127:0] store_data_t;

  // one spare bank on top for the spill after alignment
  typedef logic [159:0] wide_data_t;

  // byte count is 1 << code, codes 5..7 are illegal
  typedef enum logic [2:0] {
    size_1  = 3'd0,
    size_2  = 3'd1,
    size_4  = 3'd2,
    size_8  = 3'd3,
    size_16 = 3'd4
  } size_e;

  typedef enum logic {
    lane_empty = 1'b0,
    lane_held  = 1'b1
  } lane_state_e;

endpackage

//--- hdl/store_issue_top.sv
`timescale 1ns/1ps

module store_issue_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       st_stall,
  input  logic                       req0_valid,
  output logic                       req0_ready,
  input  store_issue_pkg::line_off_t   req0_addr,
  input  store_issue_pkg::size_e       req0_size,
  input  store_issue_pkg::store_data_t req0_data,
  input  logic                       req1_valid,
  output logic                       req1_ready,
  input  store_issue_pkg::line_off_t   req1_addr,
  input  store_issue_pkg::size_e       req1_size,
  input  store_issue_pkg::store_data_t req1_data,
  output logic                       st0_en,
  output store_issue_pkg::line_off_t   st0_addr,
  output store_issue_pkg::size_e       st0_size,
  output store_issue_pkg::bank_idx_t   st0_bgn_bank,
  output store_issue_pkg::bank_idx_t   st0_end_bank,
  output store_issue_pkg::ben_t        st0_bgn_ben,
  output store_issue_pkg::ben_t        st0_end_ben,
  output store_issue_pkg::wide_data_t  st0_data,
  output logic                       st1_en,
  output store_issue_pkg::line_off_t   st1_addr,
  output store_issue_pkg::size_e       st1_size,
  output store_issue_pkg::bank_idx_t   st1_bgn_bank,
  output store_issue_pkg::bank_idx_t   st1_end_bank,
  output store_issue_pkg::ben_t        st1_bgn_ben,
  output store_issue_pkg::ben_t        st1_end_ben,
  output store_issue_pkg::wide_data_t  st1_data
);

  import store_issue_pkg::*;

  logic       has0, has1;
  logic       issue0, issue1;
  bank_mask_t bank_mask0, bank_mask1;
  bank_idx_t  bgn_bank0, bgn_bank1;
  bank_idx_t  end_bank0, end_bank1;
  ben_t       bgn_ben0, bgn_ben1;
  ben_t       end_ben0, end_ben1;
  line_off_t  addr0, addr1;
  size_e      size0, size1;
  wide_data_t data0, data1;

  // lane 0 holds the older store
  store_lane lane0 (
    .clk(clk), .rst_n(rst_n),
    .req_valid(req0_valid), .req_addr(req0_addr), .req_size(req0_size),
    .req_data(req0_data), .issue(issue0), .req_ready(req0_ready),
    .has(has0), .bank_mask(bank_mask0), .bgn_bank(bgn_bank0), .end_bank(end_bank0),
    .bgn_ben(bgn_ben0), .end_ben(end_ben0), .addr(addr0), .size(size0), .data(data0)
  );

  store_lane lane1 (
    .clk(clk), .rst_n(rst_n),
    .req_valid(req1_valid), .req_addr(req1_addr), .req_size(req1_size),
    .req_data(req1_data), .issue(issue1), .req_ready(req1_ready),
    .has(has1), .bank_mask(bank_mask1), .bgn_bank(bgn_bank1), .end_bank(end_bank1),
    .bgn_ben(bgn_ben1), .end_ben(end_ben1), .addr(addr1), .size(size1), .data(data1)
  );

  store_pair_arbiter arb (
    .clk(clk), .rst_n(rst_n), .st_stall(st_stall),
    .has0(has0), .has1(has1), .bank_mask0(bank_mask0), .bank_mask1(bank_mask1),
    .bgn_bank0(bgn_bank0), .bgn_bank1(bgn_bank1),
    .end_bank0(end_bank0), .end_bank1(end_bank1),
    .bgn_ben0(bgn_ben0), .bgn_ben1(bgn_ben1), .end_ben0(end_ben0), .end_ben1(end_ben1),
    .addr0(addr0), .addr1(addr1), .size0(size0), .size1(size1),
    .data0(data0), .data1(data1), .issue0(issue0), .issue1(issue1),
    .st0_en(st0_en), .st0_addr(st0_addr), .st0_size(st0_size),
    .st0_bgn_bank(st0_bgn_bank), .st0_end_bank(st0_end_bank),
    .st0_bgn_ben(st0_bgn_ben), .st0_end_ben(st0_end_ben), .st0_data(st0_data),
    .st1_en(st1_en), .st1_addr(st1_addr), .st1_size(st1_size),
    .st1_bgn_bank(st1_bgn_bank), .st1_end_bank(st1_end_bank),
    .st1_bgn_ben(st1_bgn_ben), .st1_end_ben(st1_end_ben), .st1_data(st1_data)
  );

endmodule

//--- hdl/store_lane.sv
`timescale 1ns/1ps

module store_lane (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       req_valid,
  input  store_issue_pkg::line_off_t   req_addr,
  input  store_issue_pkg::size_e       req_size,
  input  store_issue_pkg::store_data_t req_data,
  input  logic                       issue,
  output logic                       req_ready,
  output logic                       has,
  output store_issue_pkg::bank_mask_t  bank_mask,
  output store_issue_pkg::bank_idx_t   bgn_bank,
  output store_issue_pkg::bank_idx_t   end_bank,
  output store_issue_pkg::ben_t        bgn_ben,
  output store_issue_pkg::ben_t        end_ben,
  output store_issue_pkg::line_off_t   addr,
  output store_issue_pkg::size_e       size,
  output store_issue_pkg::wide_data_t  data
);

  import store_issue_pkg::*;

  lane_state_e state_q;
  logic        armed_q;
  line_off_t   addr_q;
  size_e       size_q;
  store_data_t data_q;
  logic        accept;
  line_off_t   last_off;
  bank_idx_t   span_banks;
  logic        one_bank;

  // bytes from lo up to hi inside one bank
  function automatic ben_t ben_range(input logic [1:0] lo, input logic [1:0] hi);
    ben_t from_lo;
    ben_t to_hi;
    from_lo = 4'hf << lo;
    to_hi   = 4'hf >> (2'd3 - hi);
    return from_lo & to_hi;
  endfunction

  // held store can be replaced on the edge it leaves
  assign req_ready = armed_q && ((state_q == lane_empty) || issue);
  assign accept    = req_valid && req_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= lane_empty;
      armed_q <= 1'b0;
    end else begin
      armed_q <= 1'b1;
      if (accept) begin
        state_q <= lane_held;
      end else if (issue) begin
        state_q <= lane_empty;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q <= req_addr;
      size_q <= req_size;
      data_q <= req_data;
    end
  end

  assign has  = (state_q == lane_held);
  assign addr = addr_q;
  assign size = size_q;

  // last byte touched, wraps at the end of the line
  assign last_off   = addr_q + ((7'd1 << size_q) - 7'd1);
  assign bgn_bank   = addr_q[6:2];
  assign end_bank   = last_off[6:2];
  assign span_banks = end_bank - bgn_bank;
  assign one_bank   = (span_banks == '0);

  always_comb begin
    if (one_bank) begin
      bgn_ben = ben_range(addr_q[1:0], last_off[1:0]);
      end_ben = bgn_ben;
    end else begin
      bgn_ben = ben_range(addr_q[1:0], 2'd3);
      end_ben = ben_range(2'd0, last_off[1:0]);
    end
  end

  // every bank from bgn_bank through end_bank, past bank 31 included
  always_comb begin
    bank_idx_t rel;
    for (int i = 0; i < bank_count; i++) begin
      rel          = bank_idx_t'(i) - bgn_bank;
      bank_mask[i] = (rel <= span_banks);
    end
  end

  // byte lanes line up with the bank byte offset
  assign data = wide_data_t'(data_q) << {addr_q[1:0], 3'b000};

  held_size_legal: assert property (
    @(posedge clk) disable iff (!rst_n)
    (state_q == lane_held) |-> (size_q <= size_16)
  ) else $error("store_lane holds an illegal size code");

  ready_kept_when_empty: assert property (
    @(posedge clk) disable iff (!rst_n)
    (state_q == lane_empty) |-> !$fell(req_ready)
  ) else $error("store_lane dropped ready while empty");

endmodule

//--- hdl/store_pair_arbiter.sv
`timescale 1ns/1ps

module store_pair_arbiter (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      st_stall,
  input  logic                      has0,
  input  logic                      has1,
  input  store_issue_pkg::bank_mask_t bank_mask0,
  input  store_issue_pkg::bank_mask_t bank_mask1,
  input  store_issue_pkg::bank_idx_t  bgn_bank0,
  input  store_issue_pkg::bank_idx_t  bgn_bank1,
  input  store_issue_pkg::bank_idx_t  end_bank0,
  input  store_issue_pkg::bank_idx_t  end_bank1,
  input  store_issue_pkg::ben_t       bgn_ben0,
  input  store_issue_pkg::ben_t       bgn_ben1,
  input  store_issue_pkg::ben_t       end_ben0,
  input  store_issue_pkg::ben_t       end_ben1,
  input  store_issue_pkg::line_off_t  addr0,
  input  store_issue_pkg::line_off_t  addr1,
  input  store_issue_pkg::size_e      size0,
  input  store_issue_pkg::size_e      size1,
  input  store_issue_pkg::wide_data_t data0,
  input  store_issue_pkg::wide_data_t data1,
  output logic                      issue0,
  output logic                      issue1,
  output logic                      st0_en,
  output store_issue_pkg::line_off_t  st0_addr,
  output store_issue_pkg::size_e      st0_size,
  output store_issue_pkg::bank_idx_t  st0_bgn_bank,
  output store_issue_pkg::bank_idx_t  st0_end_bank,
  output store_issue_pkg::ben_t       st0_bgn_ben,
  output store_issue_pkg::ben_t       st0_end_ben,
  output store_issue_pkg::wide_data_t st0_data,
  output logic                      st1_en,
  output store_issue_pkg::line_off_t  st1_addr,
  output store_issue_pkg::size_e      st1_size,
  output store_issue_pkg::bank_idx_t  st1_bgn_bank,
  output store_issue_pkg::bank_idx_t  st1_end_bank,
  output store_issue_pkg::ben_t       st1_bgn_ben,
  output store_issue_pkg::ben_t       st1_end_ben,
  output store_issue_pkg::wide_data_t st1_data
);

  import store_issue_pkg::*;

  logic stall_q;

  // bank b lies in the wrapped range lo..hi
  function automatic logic in_range(input bank_idx_t b, input bank_idx_t lo,
                                    input bank_idx_t hi);
    bank_idx_t rel;
    bank_idx_t span;
    rel  = b - lo;
    span = hi - lo;
    return rel <= span;
  endfunction

  // younger store only rides along with lane 0
  assign issue0 = has0 && !stall_q;
  assign issue1 = issue0 && has1 && ((bank_mask0 & bank_mask1) == '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stall_q <= 1'b0;
      st0_en  <= 1'b0;
      st1_en  <= 1'b0;
    end else begin
      stall_q <= st_stall;
      st0_en  <= issue0;
      st1_en  <= issue1;
    end
  end

  always_ff @(posedge clk) begin
    if (issue0) begin
      st0_addr     <= addr0;
      st0_size     <= size0;
      st0_bgn_bank <= bgn_bank0;
      st0_end_bank <= end_bank0;
      st0_bgn_ben  <= bgn_ben0;
      st0_end_ben  <= end_ben0;
      st0_data     <= data0;
    end
    if (issue1) begin
      st1_addr     <= addr1;
      st1_size     <= size1;
      st1_bgn_bank <= bgn_bank1;
      st1_end_bank <= end_bank1;
      st1_bgn_ben  <= bgn_ben1;
      st1_end_ben  <= end_ben1;
      st1_data     <= data1;
    end
  end

  st1_needs_st0: assert property (
    @(posedge clk) disable iff (!rst_n)
    st1_en |-> st0_en
  ) else $error("st1_en without st0_en");

  // ranges overlap only if one start lies inside the other range
  pair_banks_disjoint: assert property (
    @(posedge clk) disable iff (!rst_n)
    (st0_en && st1_en) |->
      !(in_range(st1_bgn_bank, st0_bgn_bank, st0_end_bank) ||
        in_range(st0_bgn_bank, st1_bgn_bank, st1_end_bank))
  ) else $error("issued store pair shares a bank");

endmodule

//--- store_issue.f
+incdir+bench
hdl/store_issue_pkg.sv
hdl/store_lane.sv
hdl/store_pair_arbiter.sv
hdl/store_issue_top.sv
bench/store_issue_tb.sv
